// ==== common/vga_pkg.sv ====
`default_nettype none

package vga_pkg;

  // widths.
  localparam int pos_width   = 10;
  localparam int digit_width = 4;
  localparam int seg_width   = 7;
  localparam int glyph_cols  = 5;
  localparam int line_width  = 3;
  localparam int rgb_width   = 3;

  // horizontal timing in pixels, 25 MHz pixel clock.
  localparam logic [pos_width-1:0] h_display = 10'd640;
  localparam logic [pos_width-1:0] h_front   = 10'd16;
  localparam logic [pos_width-1:0] h_sync    = 10'd96;
  localparam logic [pos_width-1:0] h_back    = 10'd48;
  localparam logic [pos_width-1:0] h_total   = h_display + h_front + h_sync + h_back;

  // vertical timing in lines.
  localparam logic [pos_width-1:0] v_display = 10'd480;
  localparam logic [pos_width-1:0] v_front   = 10'd10;
  localparam logic [pos_width-1:0] v_sync    = 10'd2;
  localparam logic [pos_width-1:0] v_back    = 10'd33;
  localparam logic [pos_width-1:0] v_total   = v_display + v_front + v_sync + v_back;

  // glyph geometry. cells are 16x16, each glyph pixel is 2x2 on screen.
  localparam int cell_shift  = 4; // digit index starts at this hpos bit.
  localparam int scale_shift = 1; // column and line start at this bit.
  localparam logic [line_width-1:0] glyph_first_col = 3'd3; // columns below are blank.

  // segment bit positions in the mask.
  localparam int seg_top         = 6;
  localparam int seg_upper_right = 5;
  localparam int seg_lower_right = 4;
  localparam int seg_bottom      = 3;
  localparam int seg_lower_left  = 2;
  localparam int seg_upper_left  = 1;
  localparam int seg_middle      = 0;

  // bitmap rows, left edge is the msb.
  localparam logic [glyph_cols-1:0] row_full  = 5'b11111;
  localparam logic [glyph_cols-1:0] row_left  = 5'b10000;
  localparam logic [glyph_cols-1:0] row_right = 5'b00001;

  localparam int rgb_green = 1; // red is bit 0, blue bit 2.

endpackage

`default_nettype wire

// ==== video/hvsync_generator.sv ====
`default_nettype none

module hvsync_generator (
  input  logic                             clk,
  input  logic                             reset,
  output logic [vga_pkg::pos_width-1:0]    hpos,
  output logic [vga_pkg::pos_width-1:0]    vpos,
  output logic                             display_on,
  output logic                             hsync_raw,
  output logic                             vsync_raw
);

  localparam logic [vga_pkg::pos_width-1:0] h_last =
    vga_pkg::h_total - 10'd1;
  localparam logic [vga_pkg::pos_width-1:0] v_last =
    vga_pkg::v_total - 10'd1;

  // sync windows, 656..751 and 490..491.
  localparam logic [vga_pkg::pos_width-1:0] h_sync_first =
    vga_pkg::h_display + vga_pkg::h_front;
  localparam logic [vga_pkg::pos_width-1:0] h_sync_last =
    h_sync_first + vga_pkg::h_sync - 10'd1;
  localparam logic [vga_pkg::pos_width-1:0] v_sync_first =
    vga_pkg::v_display + vga_pkg::v_front;
  localparam logic [vga_pkg::pos_width-1:0] v_sync_last =
    v_sync_first + vga_pkg::v_sync - 10'd1;

  logic h_wrap;
  logic v_wrap;

  assign h_wrap = (hpos == h_last); // end of line.
  assign v_wrap = (vpos == v_last); // last line of frame.

  always_ff @(posedge clk) begin
    if (reset) begin
      hpos <= '0;
    end else if (h_wrap) begin
      hpos <= '0;
    end else begin
      hpos <= hpos + 10'd1;
    end
  end

  // vertical counter steps once per line.
  always_ff @(posedge clk) begin
    if (reset) begin
      vpos <= '0;
    end else if (h_wrap) begin
      if (v_wrap) begin
        vpos <= '0;
      end else begin
        vpos <= vpos + 10'd1;
      end
    end
  end

  assign display_on = (hpos < vga_pkg::h_display) && (vpos < vga_pkg::v_display);
  assign hsync_raw  = !((hpos >= h_sync_first) && (hpos <= h_sync_last)); // active low.
  assign vsync_raw  = !((vpos >= v_sync_first) && (vpos <= v_sync_last)); // active low.

  a_hpos_range: assert property (@(posedge clk) disable iff (reset)
    hpos < vga_pkg::h_total);

  a_vpos_range: assert property (@(posedge clk) disable iff (reset)
    vpos < vga_pkg::v_total);

endmodule

`default_nettype wire

// ==== glyph/seven_segment_decoder.sv ====
`default_nettype none

// segment order, msb first: top, upper right, lower right, bottom,
// lower left, upper left, middle.
module seven_segment_decoder (
  input  logic [vga_pkg::digit_width-1:0] digit,
  output logic [vga_pkg::seg_width-1:0]   segments
);

  always_comb begin
    case (digit)
      4'd0:    segments = 7'b1111110;
      4'd1:    segments = 7'b0110000;
      4'd2:    segments = 7'b1101101;
      4'd3:    segments = 7'b1111001;
      4'd4:    segments = 7'b0110011;
      4'd5:    segments = 7'b1011011;
      4'd6:    segments = 7'b1011111;
      4'd7:    segments = 7'b1110000;
      4'd8:    segments = 7'b1111111;
      4'd9:    segments = 7'b1111011;
      default: segments = 7'b0000000; // 10..15 stay dark.
    endcase
  end

endmodule

`default_nettype wire

// ==== glyph/segments_to_bitmap.sv ====
`default_nettype none

module segments_to_bitmap (
  input  logic [vga_pkg::seg_width-1:0]  segments,
  input  logic [vga_pkg::line_width-1:0] line,
  output logic [vga_pkg::glyph_cols-1:0] bits
);

  logic [vga_pkg::glyph_cols-1:0] top_row;
  logic [vga_pkg::glyph_cols-1:0] mid_row;
  logic [vga_pkg::glyph_cols-1:0] bot_row;
  logic [vga_pkg::glyph_cols-1:0] ul_edge;
  logic [vga_pkg::glyph_cols-1:0] ur_edge;
  logic [vga_pkg::glyph_cols-1:0] ll_edge;
  logic [vga_pkg::glyph_cols-1:0] lr_edge;
  logic [vga_pkg::glyph_cols-1:0] mid_left;
  logic [vga_pkg::glyph_cols-1:0] mid_right;

  // each segment masked onto the row it contributes to.
  assign top_row = {vga_pkg::glyph_cols{segments[vga_pkg::seg_top]}}    & vga_pkg::row_full;
  assign mid_row = {vga_pkg::glyph_cols{segments[vga_pkg::seg_middle]}} & vga_pkg::row_full;
  assign bot_row = {vga_pkg::glyph_cols{segments[vga_pkg::seg_bottom]}} & vga_pkg::row_full;
  assign ul_edge = {vga_pkg::glyph_cols{segments[vga_pkg::seg_upper_left]}}  & vga_pkg::row_left;
  assign ur_edge = {vga_pkg::glyph_cols{segments[vga_pkg::seg_upper_right]}} & vga_pkg::row_right;
  assign ll_edge = {vga_pkg::glyph_cols{segments[vga_pkg::seg_lower_left]}}  & vga_pkg::row_left;
  assign lr_edge = {vga_pkg::glyph_cols{segments[vga_pkg::seg_lower_right]}} & vga_pkg::row_right;

  // middle line takes an edge pixel from either vertical on that side.
  assign mid_left  = ul_edge | ll_edge;
  assign mid_right = ur_edge | lr_edge;

  // xor on the full rows clears a corner that an edge segment also hits.
  always_comb begin
    case (line)
      3'd0:    bits = top_row ^ ul_edge ^ ur_edge;
      3'd1:    bits = ul_edge ^ ur_edge;
      3'd2:    bits = mid_row ^ mid_left ^ mid_right;
      3'd3:    bits = ll_edge ^ lr_edge;
      3'd4:    bits = bot_row ^ ll_edge ^ lr_edge;
      default: bits = '0; // lines 5..7 are the gap below the glyph.
    endcase
  end

endmodule

`default_nettype wire

// ==== glyph/digit_renderer.sv ====
`default_nettype none

module digit_renderer (
  input  logic                            clk,
  input  logic                            reset,
  input  logic [vga_pkg::pos_width-1:0]   hpos,
  input  logic [vga_pkg::pos_width-1:0]   vpos,
  input  logic                            display_on,
  input  logic                            hsync_raw,
  input  logic                            vsync_raw,
  output logic                            hsync,
  output logic                            vsync,
  output logic [vga_pkg::rgb_width-1:0]   rgb
);

  logic [vga_pkg::digit_width-1:0] digit;
  logic [vga_pkg::line_width-1:0]  xofs;
  logic [vga_pkg::line_width-1:0]  yofs;
  logic [vga_pkg::line_width-1:0]  pix_idx;
  logic [vga_pkg::seg_width-1:0]   segments;
  logic [vga_pkg::glyph_cols-1:0]  bits;
  logic                            pixel;
  logic [vga_pkg::rgb_width-1:0]   rgb_next;

  assign digit = hpos[vga_pkg::cell_shift +: vga_pkg::digit_width]; // one digit per 16 pixels.
  assign xofs  = hpos[vga_pkg::scale_shift +: vga_pkg::line_width];
  assign yofs  = vpos[vga_pkg::scale_shift +: vga_pkg::line_width];

  seven_segment_decoder u_decoder (
    .digit    (digit),
    .segments (segments)
  );

  segments_to_bitmap u_bitmap (
    .segments (segments),
    .line     (yofs),
    .bits     (bits)
  );

  // column 3 maps to bit 4, column 7 to bit 0.
  assign pix_idx = {vga_pkg::line_width{1'b1}} - xofs;
  assign pixel   = (xofs >= vga_pkg::glyph_first_col) ? bits[pix_idx] : 1'b0;

  always_comb begin
    rgb_next = '0; // red and blue stay dark.
    rgb_next[vga_pkg::rgb_green] = pixel && display_on;
  end

  // colour and both syncs leave in the same stage.
  always_ff @(posedge clk) begin
    if (reset) begin
      hsync <= 1'b1;
      vsync <= 1'b1;
      rgb   <= '0;
    end else begin
      hsync <= hsync_raw;
      vsync <= vsync_raw;
      rgb   <= rgb_next;
    end
  end

  a_blank_outside: assert property (@(posedge clk) disable iff (reset)
    !display_on |=> (rgb == '0));

endmodule

`default_nettype wire

// ==== logic/seven_segment_lcd.sv ====
`default_nettype none

// digit row on a 640x480 screen, clk is the 25 MHz pixel clock.
module seven_segment_lcd (
  input  logic                          clk,
  input  logic                          reset,
  output logic                          hsync,
  output logic                          vsync,
  output logic [vga_pkg::rgb_width-1:0] rgb
);

  logic [vga_pkg::pos_width-1:0] hpos;
  logic [vga_pkg::pos_width-1:0] vpos;
  logic                          display_on;
  logic                          hsync_raw;
  logic                          vsync_raw;

  hvsync_generator u_hvsync_generator (
    .clk        (clk),
    .reset      (reset),
    .hpos       (hpos),
    .vpos       (vpos),
    .display_on (display_on),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw)
  );

  // one register stage between scan position and the pins.
  digit_renderer u_digit_renderer (
    .clk        (clk),
    .reset      (reset),
    .hpos       (hpos),
    .vpos       (vpos),
    .display_on (display_on),
    .hsync_raw  (hsync_raw),
    .vsync_raw  (vsync_raw),
    .hsync      (hsync),
    .vsync      (vsync),
    .rgb        (rgb)
  );

endmodule

`default_nettype wire

// ==== dv/tb_seven_segment_lcd.sv ====
`default_nettype none

module tb_seven_segment_lcd;
  timeunit 1ns;
  timeprecision 1ps;

  localparam logic [9:0] h_last       = 10'd799;
  localparam logic [9:0] v_last       = 10'd524;
  localparam logic [9:0] h_view       = 10'd640;
  localparam logic [9:0] v_view       = 10'd480;
  localparam logic [9:0] h_sync_first = 10'd656;
  localparam logic [9:0] h_sync_stop  = 10'd752; // first pixel after the pulse.
  localparam logic [9:0] v_sync_first = 10'd490;
  localparam logic [9:0] v_sync_stop  = 10'd492;
  localparam int         frame_timeout = 3 * 800 * 525;

  logic       clk = 1'b0;
  logic       reset = 1'b1;
  logic       hsync;
  logic       vsync;
  logic [2:0] rgb;

  // model of the position shown at the ports.
  logic       started = 1'b0;
  logic       reset_seen = 1'b0;
  logic [9:0] mh = 10'd0;
  logic [9:0] mv = 10'd0;
  int         frame_count = 0;
  int         hlow_count = 0;

  logic       exp_hsync;
  logic       exp_vsync;
  logic       exp_green;
  logic       in_view;

  seven_segment_lcd u_seven_segment_lcd (
    .clk   (clk),
    .reset (reset),
    .hsync (hsync),
    .vsync (vsync),
    .rgb   (rgb)
  );

  always #5 clk = ~clk;

  // standard abcdefg patterns, a is bit 6.
  function automatic logic [6:0] ref_segments(input logic [3:0] digit);
    case (digit)
      4'd0:    return 7'b1111110;
      4'd1:    return 7'b0110000;
      4'd2:    return 7'b1101101;
      4'd3:    return 7'b1111001;
      4'd4:    return 7'b0110011;
      4'd5:    return 7'b1011011;
      4'd6:    return 7'b1011111;
      4'd7:    return 7'b1110000;
      4'd8:    return 7'b1111111;
      4'd9:    return 7'b1111011;
      default: return 7'b0000000;
    endcase
  endfunction

  // col 0 is the left edge, col 4 the right edge.
  function automatic logic glyph_pixel(input logic [6:0] seg, input logic [2:0] row,
                                       input logic [2:0] col);
    logic full;
    logic left;
    logic right;
    full  = 1'b0;
    left  = 1'b0;
    right = 1'b0;
    case (row)
      3'd0: begin
        full  = seg[6];
        left  = seg[1];
        right = seg[5];
      end
      3'd1: begin
        left  = seg[1];
        right = seg[5];
      end
      3'd2: begin
        full  = seg[0];
        left  = seg[1] | seg[2];
        right = seg[5] | seg[4];
      end
      3'd3: begin
        left  = seg[2];
        right = seg[4];
      end
      3'd4: begin
        full  = seg[3];
        left  = seg[2];
        right = seg[4];
      end
      default: ; // gap under the glyph.
    endcase
    if (col == 3'd0) return full ^ left;
    if (col == 3'd4) return full ^ right;
    return full;
  endfunction

  function automatic logic ref_green(input logic [9:0] h, input logic [9:0] v);
    logic [2:0] col;
    if (!((h < h_view) && (v < v_view))) return 1'b0;
    col = h[3:1];
    if (col < 3'd3) return 1'b0; // left margin of the cell.
    return glyph_pixel(ref_segments(h[7:4]), v[3:1], col - 3'd3);
  endfunction

  assign in_view   = (mh < h_view) && (mv < v_view);
  assign exp_hsync = !((mh >= h_sync_first) && (mh < h_sync_stop));
  assign exp_vsync = !((mv >= v_sync_first) && (mv < v_sync_stop));
  assign exp_green = ref_green(mh, mv);

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("sim failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_mismatch(input string check, input int expected, input int actual);
    stop_run($sformatf("[FAIL] %s expected %0d actual %0d", check, expected, actual));
  endtask

  // position (0,0) reaches the ports one clock after reset drops.
  always @(posedge clk) begin
    reset_seen <= reset;
    if (reset) begin
      started     <= 1'b0;
      mh          <= 10'd0;
      mv          <= 10'd0;
      frame_count <= 0;
    end else if (!started) begin
      started <= 1'b1;
    end else if (mh == h_last) begin
      mh <= 10'd0;
      if (mv == v_last) begin
        mv          <= 10'd0;
        frame_count <= frame_count + 1;
      end else begin
        mv <= mv + 10'd1;
      end
    end else begin
      mh <= mh + 10'd1;
    end
  end

  // low cycles of hsync over the current line.
  always @(posedge clk) begin
    if (started) begin
      if (mh == 10'd0) begin
        hlow_count <= hsync ? 0 : 1;
      end else if (!hsync) begin
        hlow_count <= hlow_count + 1;
      end
    end
  end

  // checks sit on the falling edge, where the ports are settled.
  a_reset_values: assert property (@(negedge clk)
    reset_seen |-> (hsync && vsync && (rgb == 3'd0)))
    else report_mismatch("a_reset_values", 24, int'({hsync, vsync, rgb}));

  a_hsync_level: assert property (@(negedge clk) started |-> (hsync == exp_hsync))
    else report_mismatch("a_hsync_level", int'(exp_hsync), int'(hsync));

  a_hsync_width: assert property (@(negedge clk)
    (started && (mh == 10'd0) && ((mv != 10'd0) || (frame_count != 0))) |-> (hlow_count == 96))
    else report_mismatch("a_hsync_width", 96, hlow_count);

  a_vsync_level: assert property (@(negedge clk) started |-> (vsync == exp_vsync))
    else report_mismatch("a_vsync_level", int'(exp_vsync), int'(vsync));

  a_red_blue_off: assert property (@(negedge clk) started |-> ((rgb[0] == 1'b0) && (rgb[2] == 1'b0)))
    else report_mismatch("a_red_blue_off", 0, int'({rgb[2], rgb[0]}));

  a_dark_border: assert property (@(negedge clk) (started && !in_view) |-> (rgb == 3'd0))
    else report_mismatch("a_dark_border", 0, int'(rgb));

  a_glyph_pixel: assert property (@(negedge clk) started |-> (rgb[1] == exp_green))
    else report_mismatch("a_glyph_pixel", int'(exp_green), int'(rgb[1]));

  initial begin
    int wait_cycles;
    wait_cycles = 0;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    while ((frame_count < 2) && (wait_cycles < frame_timeout)) begin
      @(negedge clk);
      wait_cycles = wait_cycles + 1;
    end
    if (frame_count >= 2) begin
      $display("sim passed");
      $finish;
    end else begin
      stop_run("timeout while waiting for two full frames");
    end
  end

endmodule

`default_nettype wire

// ==== sim.f ====
common/vga_pkg.sv
video/hvsync_generator.sv
glyph/seven_segment_decoder.sv
glyph/segments_to_bitmap.sv
glyph/digit_renderer.sv
logic/seven_segment_lcd.sv
dv/tb_seven_segment_lcd.sv

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator and run it from the project root.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sim.f \
  --top-module tb_seven_segment_lcd -Mdir obj_dir \
  && ./obj_dir/Vtb_seven_segment_lcd \
  || exit 1
